// File: Bender.yml
package:
  name: host_link

sources:
  - src/host_link_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/byte_fifo.sv
  - src/host_link_ctrl.sv
  - src/host_link_top.sv
  - target: test
    files:
      - dv/host_link_checker.sv
      - dv/tb_host_link.sv

// File: dv/host_link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module host_link_checker #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      txd,
    input  logic                      prog_we,
    input  host_link_pkg::word_addr_t prog_addr,
    input  host_link_pkg::word_t      prog_wdata,
    input  logic                      stdin_pop,
    input  host_link_pkg::byte_t      stdin_data,
    input  logic                      stdin_empty
);

    string                     test_name = "reset";
    host_link_pkg::byte_t      exp_tx[$];
    host_link_pkg::word_addr_t exp_addr[$];
    host_link_pkg::word_t      exp_word[$];
    host_link_pkg::byte_t      exp_stdin[$];
    int                        mismatch_count = 0;
    int                        other_count = 0;

    task automatic compare(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("mismatch %s %s: expected 0x%0h actual 0x%0h",
                     test_name, what, exp_val, act_val);
            mismatch_count++;
        end
    endtask

    task automatic report(input string what);
        $display("error in %s: %s", test_name, what);
        other_count++;
    endtask

    task automatic check_drained();
        if (exp_tx.size() != 0) report("expected bytes never appeared on txd");
        if (exp_word.size() != 0) report("expected program writes never happened");
        if (exp_stdin.size() != 0) report("expected stdin bytes were never read back");
    endtask

    // frame decoder, samples near bit centres on the falling clock
    always begin : decode_txd
        host_link_pkg::byte_t frame;
        int                   i;
        @(negedge txd);
        if (reset_n) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (txd !== 1'b0) report("start bit on txd ended too early");
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                frame[i] = txd;  // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (txd !== 1'b1) report("stop bit on txd was low");
            if (exp_tx.size() == 0) begin
                report($sformatf("unexpected byte 0x%0h on txd", frame));
            end else begin
                compare("txd byte", exp_tx[0], frame);
                void'(exp_tx.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n && prog_we) begin
            if (exp_word.size() == 0) begin
                report($sformatf("unexpected program write at address %0d", prog_addr));
            end else begin
                compare("prog_addr", exp_addr.pop_front(), prog_addr);
                compare("prog_wdata", exp_word.pop_front(), prog_wdata);
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n && stdin_pop) begin
            if (stdin_empty) report("stdin buffer popped while empty");
            else if (exp_stdin.size() == 0) report("stdin buffer held an unexpected byte");
            else compare("stdin_data", exp_stdin.pop_front(), stdin_data);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_host_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_link;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int MAX_PROG_LEN = 23;
    localparam int STDIN_LEN    = 6;
    // every frame of every test, program at its longest, plus idle bits
    localparam int TOTAL_FRAMES = 2 + 4 + MAX_PROG_LEN + STDIN_LEN + FIFO_DEPTH + 2
                                + FIFO_DEPTH + 1;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 10 * CLKS_PER_BIT + 2000;

    logic                      clk;
    logic                      reset_n;
    logic                      rxd;
    logic                      txd;
    logic                      send_ready;
    logic                      send_done;
    logic                      recv_size;
    logic                      recv_program;
    logic                      recv_stdin;
    logic                      send_stdout;
    logic                      ready_sent;
    logic                      done_sent;
    logic                      size_done;
    logic                      program_done;
    logic                      prog_we;
    host_link_pkg::word_addr_t prog_addr;
    host_link_pkg::word_t      prog_wdata;
    logic                      stdin_pop;
    host_link_pkg::byte_t      stdin_data;
    logic                      stdin_empty;
    logic                      stdout_push;
    host_link_pkg::byte_t      stdout_push_data;
    logic                      stdout_full;
    logic                      frame_error;
    logic                      stdin_overrun;

    host_link_pkg::byte_t      prog_bytes[$];
    host_link_pkg::prog_len_t  prog_len;
    host_link_pkg::byte_t      rand_byte;
    int                        cycle_count;
    int                        errors;

    host_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

    host_link_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_checker (
        .clk, .reset_n, .txd, .prog_we, .prog_addr, .prog_wdata,
        .stdin_pop, .stdin_data, .stdin_empty
    );

    always #2 clk = ~clk;

    // packs bytes low first, zero fill beyond the end of the list
    function automatic host_link_pkg::word_t expected_word(
        input host_link_pkg::byte_t bytes[$], input int idx);
        host_link_pkg::word_t word;
        int                   b;
        word = '0;
        for (b = 0; b < 4; b++) begin
            if (idx * 4 + b < bytes.size()) word[b*8 +: 8] = bytes[idx * 4 + b];
        end
        return word;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic hold_bit(input logic value);
        rxd = value;
        repeat (CLKS_PER_BIT) next_cycle();
    endtask

    task automatic serial_send(input host_link_pkg::byte_t data, input logic stop_bit);
        int i;
        hold_bit(1'b0);
        for (i = 0; i < 8; i++) hold_bit(data[i]);
        hold_bit(stop_bit);
        rxd = 1'b1;
    endtask

    task automatic pop_stdin();
        while (stdin_empty) next_cycle();
        stdin_pop = 1'b1;
        next_cycle();
        stdin_pop = 1'b0;
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other",
                 i_checker.mismatch_count, i_checker.other_count);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: test %s still running after %0d cycles",
                     i_checker.test_name, TIMEOUT_CYCLES);
            print_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        rxd = 1'b1;
        send_ready = 1'b0;
        send_done = 1'b0;
        recv_size = 1'b0;
        recv_program = 1'b0;
        recv_stdin = 1'b0;
        send_stdout = 1'b0;
        stdin_pop = 1'b0;
        stdout_push = 1'b0;
        stdout_push_data = '0;
        cycle_count = 0;
        void'($urandom(32'hf4f66ea4));
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (4) next_cycle();

        i_checker.test_name = "handshake";
        i_checker.exp_tx.push_back(8'h99);
        i_checker.exp_tx.push_back(8'hAA);
        send_ready = 1'b1;
        while (!ready_sent) next_cycle();
        send_done = 1'b1;
        while (!done_sent) next_cycle();
        while (i_checker.exp_tx.size() != 0) next_cycle();
        send_ready = 1'b0;
        send_done = 1'b0;
        next_cycle();
        i_checker.compare("ready_sent after drop", 1'b0, ready_sent);
        i_checker.compare("done_sent after drop", 1'b0, done_sent);

        i_checker.test_name = "program";
        prog_len = $urandom_range(MAX_PROG_LEN, 1);
        for (int i = 0; i < prog_len; i++) prog_bytes.push_back(8'($urandom));
        for (int w = 0; w < (prog_len + 3) / 4; w++) begin
            i_checker.exp_addr.push_back(16'(w));
            i_checker.exp_word.push_back(expected_word(prog_bytes, w));
        end
        recv_size = 1'b1;
        for (int i = 0; i < 4; i++) serial_send(prog_len[i*8 +: 8], 1'b1);
        while (!size_done) next_cycle();
        recv_size = 1'b0;
        recv_program = 1'b1;
        foreach (prog_bytes[i]) serial_send(prog_bytes[i], 1'b1);
        while (!program_done) next_cycle();
        recv_program = 1'b0;
        next_cycle();
        i_checker.compare("program_done after drop", 1'b0, program_done);

        i_checker.test_name = "stdin";
        recv_stdin = 1'b1;
        for (int i = 0; i < STDIN_LEN; i++) begin
            rand_byte = 8'($urandom);
            i_checker.exp_stdin.push_back(rand_byte);
            serial_send(rand_byte, 1'b1);
            pop_stdin();
        end
        recv_stdin = 1'b0;

        i_checker.test_name = "stdout";
        i_checker.compare("stdout_full before pushes", 1'b0, stdout_full);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            stdout_push_data = 8'($urandom);
            stdout_push = 1'b1;
            i_checker.exp_tx.push_back(stdout_push_data);
            next_cycle();
        end
        stdout_push = 1'b0;
        i_checker.compare("stdout_full after pushes", 1'b1, stdout_full);
        send_stdout = 1'b1;
        while (i_checker.exp_tx.size() != 0) next_cycle();
        send_stdout = 1'b0;

        i_checker.test_name = "framing";
        recv_stdin = 1'b1;
        serial_send(8'h5a, 1'b0);
        hold_bit(1'b1);  // idle so the receiver sees the next start edge
        i_checker.compare("frame_error", 1'b1, frame_error);
        i_checker.compare("stdin_empty", 1'b1, stdin_empty);

        i_checker.test_name = "overrun";
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            rand_byte = 8'($urandom);
            if (i < FIFO_DEPTH) i_checker.exp_stdin.push_back(rand_byte);
            serial_send(rand_byte, 1'b1);
        end
        next_cycle();
        i_checker.compare("stdin_overrun", 1'b1, stdin_overrun);
        for (int i = 0; i < FIFO_DEPTH; i++) pop_stdin();
        i_checker.compare("stdin_empty after reads", 1'b1, stdin_empty);
        recv_stdin = 1'b0;

        repeat (4) next_cycle();
        i_checker.test_name = "end";
        i_checker.check_drained();
        errors = i_checker.mismatch_count + i_checker.other_count;
        print_counts();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 push,
    input  host_link_pkg::byte_t push_data,
    input  logic                 pop,
    output host_link_pkg::byte_t head,
    output logic                 full,
    output logic                 empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    host_link_pkg::byte_t mem [FIFO_DEPTH];
    logic [ADDR_W:0]      wr_ptr;  // extra bit tells full from empty
    logic [ADDR_W:0]      rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
                  && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr[ADDR_W-1:0]];  // oldest entry

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr[ADDR_W-1:0]] <= push_data;
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        push |-> !full)
        else $error("byte_fifo: push while full, byte ignored");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        pop |-> !empty)
        else $error("byte_fifo: pop while empty, ignored");

endmodule

`default_nettype wire

// File: src/host_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module host_link_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  host_link_pkg::byte_t      rx_data,
    input  logic                      rx_valid,
    input  logic                      rx_ferr,
    output host_link_pkg::byte_t      tx_data,
    output logic                      tx_start,
    input  logic                      tx_busy,
    input  logic                      send_ready,
    input  logic                      send_done,
    input  logic                      recv_size,
    input  logic                      recv_program,
    input  logic                      recv_stdin,
    input  logic                      send_stdout,
    output logic                      ready_sent,
    output logic                      done_sent,
    output logic                      size_done,
    output logic                      program_done,
    output logic                      prog_we,
    output host_link_pkg::word_addr_t prog_addr,
    output host_link_pkg::word_t      prog_wdata,
    output logic                      stdin_push,
    output host_link_pkg::byte_t      stdin_push_data,
    input  logic                      stdin_full,
    output logic                      stdout_pop,
    input  host_link_pkg::byte_t      stdout_head,
    input  logic                      stdout_empty,
    output logic                      frame_error,
    output logic                      stdin_overrun
);

    logic [1:0]                lane;      // byte position inside a word
    host_link_pkg::prog_len_t  prog_len;
    host_link_pkg::prog_len_t  byte_cnt;
    host_link_pkg::word_addr_t word_addr;
    host_link_pkg::word_t      word_acc;
    host_link_pkg::word_t      word_next;
    logic                      size_byte;
    logic                      prog_byte;
    logic                      prog_last;
    logic                      word_full;
    logic                      stdin_byte;
    logic                      tx_free;
    logic                      start_ready;
    logic                      start_done;
    logic                      start_out;

    assign size_byte  = rx_valid && recv_size && !size_done;
    assign prog_byte  = rx_valid && recv_program && !program_done;
    assign prog_last  = (byte_cnt + 32'd1) == prog_len;
    assign word_full  = prog_byte && (lane == 2'd3 || prog_last);
    assign stdin_byte = rx_valid && recv_stdin;

    always_comb begin
        word_next = word_acc;
        word_next[lane*8 +: 8] = rx_data;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lane          <= '0;
            byte_cnt      <= '0;
            word_addr     <= '0;
            word_acc      <= '0;
            size_done     <= 1'b0;
            program_done  <= 1'b0;
            prog_we       <= 1'b0;
            prog_addr     <= '0;
            stdin_push    <= 1'b0;
            frame_error   <= 1'b0;
            stdin_overrun <= 1'b0;
        end else begin
            prog_we    <= 1'b0;
            stdin_push <= 1'b0;
            if (size_byte || prog_byte) lane <= lane + 2'd1;
            else if (!recv_size && !recv_program) lane <= '0;
            if (size_byte && lane == 2'd3) size_done <= 1'b1;
            else if (!recv_size) size_done <= 1'b0;
            if (prog_byte) begin
                byte_cnt <= byte_cnt + 32'd1;
                word_acc <= word_full ? '0 : word_next;
                if (word_full) begin
                    prog_we   <= 1'b1;
                    prog_addr <= word_addr;
                    word_addr <= word_addr + 16'd1;
                end
                if (prog_last) program_done <= 1'b1;
            end else if (!recv_program) begin  // restart between phases
                byte_cnt     <= '0;
                word_acc     <= '0;
                word_addr    <= '0;
                program_done <= 1'b0;
            end
            if (stdin_byte) begin
                if (stdin_full) stdin_overrun <= 1'b1;  // byte dropped
                else stdin_push <= 1'b1;
            end
            if (rx_ferr) frame_error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (size_byte) prog_len[lane*8 +: 8] <= rx_data;
        if (word_full) prog_wdata <= word_next;
        if (stdin_byte && !stdin_full) stdin_push_data <= rx_data;
    end

    // fixed priority ready, done, stdout
    assign tx_free     = !tx_busy && !tx_start;
    assign start_ready = tx_free && send_ready && !ready_sent;
    assign start_done  = tx_free && send_done && !done_sent && !start_ready;
    assign start_out   = tx_free && send_stdout && !stdout_empty && !start_ready && !start_done;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            tx_start   <= 1'b0;
            stdout_pop <= 1'b0;
            ready_sent <= 1'b0;
            done_sent  <= 1'b0;
        end else begin
            tx_start   <= start_ready || start_done || start_out;
            stdout_pop <= start_out;
            if (start_ready) ready_sent <= 1'b1;
            else if (!send_ready) ready_sent <= 1'b0;
            if (start_done) done_sent <= 1'b1;
            else if (!send_done) done_sent <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ready) tx_data <= host_link_pkg::READY_CODE;
        else if (start_done) tx_data <= host_link_pkg::DONE_CODE;
        else if (start_out) tx_data <= stdout_head;
    end

    a_prog_we_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        prog_we |=> !prog_we)
        else $error("host_link_ctrl: prog_we wider than one cycle");

endmodule

`default_nettype wire

// File: src/host_link_pkg.sv
`default_nettype none

package host_link_pkg;

    // serial payload
    typedef logic [7:0] byte_t;

    // one program memory word, packed little endian
    typedef logic [31:0] word_t;

    // word address into program memory
    typedef logic [15:0] word_addr_t;

    // program length as sent by the host, in bytes
    typedef logic [31:0] prog_len_t;

    // handshake codes answered to the host
    localparam byte_t READY_CODE = 8'h99;
    localparam byte_t DONE_CODE  = 8'hAA;

endpackage

`default_nettype wire

// File: src/host_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_link_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      rxd,
    output logic                      txd,
    input  logic                      send_ready,
    input  logic                      send_done,
    input  logic                      recv_size,
    input  logic                      recv_program,
    input  logic                      recv_stdin,
    input  logic                      send_stdout,
    output logic                      ready_sent,
    output logic                      done_sent,
    output logic                      size_done,
    output logic                      program_done,
    output logic                      prog_we,
    output host_link_pkg::word_addr_t prog_addr,
    output host_link_pkg::word_t      prog_wdata,
    input  logic                      stdin_pop,
    output host_link_pkg::byte_t      stdin_data,
    output logic                      stdin_empty,
    input  logic                      stdout_push,
    input  host_link_pkg::byte_t      stdout_push_data,
    output logic                      stdout_full,
    output logic                      frame_error,
    output logic                      stdin_overrun
);

    host_link_pkg::byte_t rx_data;
    logic                 rx_valid;
    logic                 rx_ferr;
    host_link_pkg::byte_t tx_data;
    logic                 tx_start;
    logic                 tx_busy;
    logic                 stdin_push;
    host_link_pkg::byte_t stdin_push_data;
    logic                 stdin_full;
    logic                 stdout_pop;
    host_link_pkg::byte_t stdout_head;
    logic                 stdout_empty;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
        .clk, .reset_n, .rxd, .rx_data, .rx_valid, .rx_ferr
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk, .reset_n, .tx_data, .tx_start, .tx_busy, .txd
    );

    host_link_ctrl i_ctrl (.*);

    // host to CPU
    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_stdin_fifo (
        .clk, .reset_n, .push(stdin_push), .push_data(stdin_push_data),
        .pop(stdin_pop), .head(stdin_data), .full(stdin_full), .empty(stdin_empty)
    );

    // CPU to host
    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_stdout_fifo (
        .clk, .reset_n, .push(stdout_push), .push_data(stdout_push_data),
        .pop(stdout_pop), .head(stdout_head), .full(stdout_full), .empty(stdout_empty)
    );

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 rxd,
    output host_link_pkg::byte_t rx_data,
    output logic                 rx_valid,
    output logic                 rx_ferr
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t           state;
    logic             rxd_meta;
    logic             rxd_s;
    logic             rxd_d;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             sample;

    assign sample = (clk_cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_d    <= 1'b1;
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_ferr  <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_d    <= rxd_s;
            rx_valid <= 1'b0;
            rx_ferr  <= 1'b0;
            clk_cnt  <= sample ? '0 : clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (rxd_d && !rxd_s) state <= S_START;  // falling edge
                end
                S_START: begin
                    if (clk_cnt == CNT_HALF) begin
                        clk_cnt <= '0;  // realign to bit centre
                        bit_cnt <= '0;
                        state   <= rxd_s ? S_IDLE : S_DATA;  // glitch filter
                    end
                end
                S_DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= S_STOP;
                    end
                end
                default: begin
                    if (sample) begin
                        rx_valid <= rxd_s;
                        rx_ferr  <= !rxd_s;  // low stop bit drops the byte
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DATA && sample) rx_data <= {rxd_s, rx_data[7:1]};  // lsb first
    end

    a_valid_ferr_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(rx_valid && rx_ferr))
        else $error("uart_rx: rx_valid and rx_ferr high together");

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  host_link_pkg::byte_t tx_data,
    input  logic                 tx_start,
    output logic                 tx_busy,
    output logic                 txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;  // bits finished in this frame
    logic [8:0]       shift;    // data bits then stop bit
    logic             bit_end;

    assign bit_end = tx_busy && (clk_cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (tx_start) begin
            tx_busy <= 1'b1;
            txd     <= 1'b0;  // start bit
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // stop bit done, line stays high
            end else begin
                txd     <= shift[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else if (tx_busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) shift <= {1'b1, tx_data};
        else if (bit_end) shift <= {1'b1, shift[8:1]};
    end

    // the controller must wait for busy to drop before the next byte
    a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
        tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while busy");

endmodule

`default_nettype wire

// File: tb.f
src/host_link_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/byte_fifo.sv
src/host_link_ctrl.sv
src/host_link_top.sv
dv/host_link_checker.sv
dv/tb_host_link.sv
